// File: bench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int directed_ops = 42;
    localparam int random_ops   = 2000;
    // A miss takes at most 11 cycles including the longest memory delay.
    localparam int cycle_limit  = (directed_ops + random_ops) * 12 + 200;

    logic                            clk_i = 1'b0;
    logic                            rst_n_i;
    logic                            req_i;
    logic                            we_i;
    logic [`DCACHE_ADDR_WIDTH-1:0]   addr_i;
    memop_size_e                     size_i;
    logic [`DCACHE_WORD_WIDTH-1:0]   wdata_i;
    logic                            rsp_valid_o;
    logic [`DCACHE_WORD_WIDTH-1:0]   rdata_o;
    logic                            busy_o;
    logic                            mem_rd_req_o;
    logic [`DCACHE_ADDR_WIDTH-1:0]   mem_rd_addr_o;
    logic                            mem_rsp_valid_i;
    dcache_line_t                    mem_rsp_line_i;
    logic                            mem_wr_o;
    logic [`DCACHE_ADDR_WIDTH-1:0]   mem_wr_addr_o;
    logic [`DCACHE_WORD_WIDTH-1:0]   mem_wr_data_o;
    logic [`DCACHE_WORD_WIDTH/8-1:0] mem_wr_be_o;

    integer      seed;
    int          cycle_count = 0;
    // Reference memory. Bytes never written read as a hash of their address.
    logic [7:0]  mem_model [logic [`DCACHE_ADDR_WIDTH-1:0]];
    logic        line_valid [`DCACHE_NUM_LINES];
    dcache_tag_t line_tag [`DCACHE_NUM_LINES];
    dcache_tag_t tag_pool [4];

    dcache_top UUT (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_load(input logic [`DCACHE_WORD_WIDTH-1:0] got,
                              input logic [`DCACHE_WORD_WIDTH-1:0] exp,
                              input logic [`DCACHE_ADDR_WIDTH-1:0] addr);
        if (got !== exp) begin
            report_error($sformatf("load from %h returned %h, expected %h", addr, got, exp));
        end
    endtask

    task automatic check_refill(input logic [`DCACHE_ADDR_WIDTH-1:0] got,
                                input logic [`DCACHE_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("refill address %h, expected %h", got, exp));
        end
    endtask

    task automatic check_mem_write(input logic [`DCACHE_ADDR_WIDTH-1:0]   got_addr,
                                   input logic [`DCACHE_WORD_WIDTH-1:0]   got_data,
                                   input logic [`DCACHE_WORD_WIDTH/8-1:0] got_be,
                                   input logic [`DCACHE_ADDR_WIDTH-1:0]   exp_addr,
                                   input logic [`DCACHE_WORD_WIDTH-1:0]   exp_data,
                                   input logic [`DCACHE_WORD_WIDTH/8-1:0] exp_be);
        logic [`DCACHE_WORD_WIDTH-1:0] mask;
        for (int b = 0; b < `DCACHE_WORD_WIDTH / 8; b++) begin
            mask[8*b +: 8] = {8{exp_be[b]}};
        end
        // Only enabled lanes carry data.
        if (got_addr !== exp_addr || got_be !== exp_be || (got_data & mask) !== exp_data) begin
            report_error($sformatf("write-through %h/%h/%b, expected %h/%h/%b",
                                   got_addr, got_data & mask, got_be,
                                   exp_addr, exp_data, exp_be));
        end
    endtask

    function automatic logic [7:0] read_byte(input logic [`DCACHE_ADDR_WIDTH-1:0] a);
        logic [31:0] h;
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 13);
        return h[7:0] ^ h[31:24];
    endfunction

    function automatic int size_bytes(input memop_size_e size);
        case (size)
            MEM_BYTE: return 1;
            MEM_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    function automatic logic [`DCACHE_WORD_WIDTH-1:0] model_load(
        input logic [`DCACHE_ADDR_WIDTH-1:0] addr, input memop_size_e size);
        logic [`DCACHE_WORD_WIDTH-1:0] value;
        value = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            value[8*k +: 8] = read_byte(addr + 32'(k));
        end
        return value;
    endfunction

    function automatic dcache_line_t model_line(input logic [`DCACHE_ADDR_WIDTH-1:0] base);
        dcache_line_t line;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            line[b] = read_byte(base + 32'(b));
        end
        return line;
    endfunction

    function automatic logic [`DCACHE_ADDR_WIDTH-1:0] make_addr(
        input dcache_tag_t t, input dcache_index_t idx, input dcache_offset_t off);
        return {t, idx, off};
    endfunction

    task automatic wait_idle();
        while (busy_o) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // Answers a refill after 1 to 8 cycles.
    task automatic serve_refill(input logic [`DCACHE_ADDR_WIDTH-1:0] base);
        int delay;
        int waited;
        delay = 1 + int'($unsigned($random(seed)) % 8);
        repeat (delay) begin
            @(posedge clk_i);
            #2;
            check_strobe(mem_rd_req_o, 1'b0, "mem_rd_req_o after its first cycle");
            check_strobe(busy_o, 1'b1, "busy_o while a refill is pending");
        end
        mem_rsp_valid_i = 1'b1;
        mem_rsp_line_i  = model_line(base);
        waited = 0;
        do begin
            @(posedge clk_i);
            #2;
            mem_rsp_valid_i = 1'b0;
            waited++;
        end while (!rsp_valid_o);
        if (waited != 2) begin
            report_error($sformatf("response %0d cycles after mem_rsp_valid_i, expected 2",
                                   waited));
        end
    endtask

    task automatic do_load(input logic [`DCACHE_ADDR_WIDTH-1:0] addr, input memop_size_e size);
        dcache_index_t                 idx;
        dcache_tag_t                   t;
        logic                          exp_hit;
        logic [`DCACHE_WORD_WIDTH-1:0] expected;
        idx      = addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
        t        = addr[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_BITS];
        exp_hit  = line_valid[idx] && (line_tag[idx] == t);
        expected = model_load(addr, size);
        wait_idle();
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = addr;
        size_i = size;
        @(posedge clk_i);
        #2;
        req_i = 1'b0;
        check_strobe(mem_rd_req_o, !exp_hit, "mem_rd_req_o one cycle after a load");
        check_strobe(rsp_valid_o, exp_hit, "rsp_valid_o one cycle after a load");
        if (!exp_hit) begin
            check_strobe(busy_o, 1'b1, "busy_o at the start of a refill");
            check_refill(mem_rd_addr_o, {addr[`DCACHE_ADDR_WIDTH-1:4], 4'h0});
            serve_refill({addr[`DCACHE_ADDR_WIDTH-1:4], 4'h0});
            line_valid[idx] = 1'b1;
            line_tag[idx]   = t;
        end
        check_strobe(busy_o, 1'b0, "busy_o with the load response");
        check_load(rdata_o, expected, addr);
    endtask

    task automatic do_store(input logic [`DCACHE_ADDR_WIDTH-1:0] addr, input memop_size_e size,
                            input logic [`DCACHE_WORD_WIDTH-1:0] data);
        int                              lane;
        logic [`DCACHE_WORD_WIDTH-1:0]   exp_data;
        logic [`DCACHE_WORD_WIDTH/8-1:0] exp_be;
        lane     = int'(addr[1:0]);
        exp_data = '0;
        exp_be   = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            exp_be[lane + k]             = 1'b1;
            exp_data[8*(lane + k) +: 8] = data[8*k +: 8];
        end
        wait_idle();
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        size_i  = size;
        wdata_i = data;
        @(posedge clk_i);
        #2;
        req_i = 1'b0;
        we_i  = 1'b0;
        check_strobe(mem_wr_o, 1'b1, "mem_wr_o one cycle after a store");
        check_strobe(busy_o, 1'b0, "busy_o after a store");
        check_strobe(mem_rd_req_o, 1'b0, "mem_rd_req_o after a store");
        check_strobe(rsp_valid_o, 1'b0, "rsp_valid_o after a store");
        check_mem_write(mem_wr_addr_o, mem_wr_data_o, mem_wr_be_o,
                        {addr[`DCACHE_ADDR_WIDTH-1:2], 2'b00}, exp_data, exp_be);
        for (int k = 0; k < size_bytes(size); k++) begin
            mem_model[addr + 32'(k)] = data[8*k +: 8];
        end
        @(posedge clk_i);
        #2;
        check_strobe(mem_wr_o, 1'b0, "mem_wr_o two cycles after a store");
    endtask

    initial begin
        dcache_index_t  idx;
        dcache_offset_t off;
        memop_size_e    sz;
        int             pick;
        seed            = 91;
        rst_n_i         = 1'b0;
        req_i           = 1'b0;
        we_i            = 1'b0;
        addr_i          = '0;
        size_i          = MEM_WORD;
        wdata_i         = '0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i  = '0;
        tag_pool[0]     = 25'h0000001;
        tag_pool[1]     = 25'h0001234;
        tag_pool[2]     = 25'h0abcdef;
        tag_pool[3]     = 25'h1ffffff;
        for (int i = 0; i < `DCACHE_NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_strobe(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
        check_strobe(mem_rd_req_o, 1'b0, "mem_rd_req_o after reset");
        check_strobe(mem_wr_o, 1'b0, "mem_wr_o after reset");
        check_strobe(busy_o, 1'b0, "busy_o after reset");

        // Cold loads, then byte and half hits on every line.
        for (int i = 0; i < `DCACHE_NUM_LINES; i++) begin
            do_load(make_addr(tag_pool[0], dcache_index_t'(i), dcache_offset_t'(4 * (i % 4))),
                    MEM_WORD);
        end
        for (int i = 0; i < `DCACHE_NUM_LINES; i++) begin
            do_load(make_addr(tag_pool[0], dcache_index_t'(i), dcache_offset_t'(i)), MEM_BYTE);
            do_load(make_addr(tag_pool[0], dcache_index_t'(i), dcache_offset_t'(2 * i)),
                    MEM_HALF);
        end

        // Stores that hit, then stores that miss, each read back.
        do_store(make_addr(tag_pool[0], 3'd1, 4'd3), MEM_BYTE, $random(seed));
        do_store(make_addr(tag_pool[0], 3'd1, 4'd6), MEM_HALF, $random(seed));
        do_store(make_addr(tag_pool[0], 3'd1, 4'd8), MEM_WORD, $random(seed));
        do_load(make_addr(tag_pool[0], 3'd1, 4'd0), MEM_WORD);
        do_load(make_addr(tag_pool[0], 3'd1, 4'd4), MEM_WORD);
        do_load(make_addr(tag_pool[0], 3'd1, 4'd8), MEM_WORD);
        do_store(make_addr(tag_pool[2], 3'd2, 4'd1), MEM_BYTE, $random(seed));
        do_store(make_addr(tag_pool[2], 3'd2, 4'd10), MEM_HALF, $random(seed));
        do_store(make_addr(tag_pool[2], 3'd2, 4'd12), MEM_WORD, $random(seed));
        do_load(make_addr(tag_pool[2], 3'd2, 4'd0), MEM_WORD);
        do_load(make_addr(tag_pool[2], 3'd2, 4'd8), MEM_WORD);
        do_load(make_addr(tag_pool[2], 3'd2, 4'd12), MEM_WORD);

        // Two tags fighting over line 5 miss every time.
        for (int i = 0; i < 6; i++) begin
            do_load(make_addr(tag_pool[(i % 2 == 0) ? 1 : 0], 3'd5, 4'd0), MEM_WORD);
        end

        for (int n = 0; n < random_ops; n++) begin
            pick = $unsigned($random(seed)) % 4;
            idx  = dcache_index_t'($unsigned($random(seed)) % 8);
            off  = dcache_offset_t'($random(seed));
            case ($unsigned($random(seed)) % 3)
                0:       sz = MEM_BYTE;
                1:       sz = MEM_HALF;
                default: sz = MEM_WORD;
            endcase
            if (sz == MEM_HALF)
                off[0] = 1'b0;
            if (sz == MEM_WORD)
                off[1:0] = 2'b00;
            if ($unsigned($random(seed)) % 2 == 1)
                do_store(make_addr(tag_pool[pick], idx, off), sz, $random(seed));
            else
                do_load(make_addr(tag_pool[pick], idx, off), sz);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule : tb_dcache

`default_nettype wire

// File: build.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_data_if.sv
hw/dcache_data.sv
hw/dcache_tag.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
bench/tb_dcache.sv

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [`DCACHE_ADDR_WIDTH-1:0]   addr_i,
    input  dcache_pkg::memop_size_e         size_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]   wdata_i,
    output logic                            rsp_valid_o,
    output logic                            busy_o,
    input  logic                            hit_i,
    output logic                            tag_fill_o,
    output dcache_pkg::dcache_index_t       lookup_index_o,
    output dcache_pkg::dcache_tag_t         lookup_tag_o,
    output logic                            mem_rd_req_o,
    output logic [`DCACHE_ADDR_WIDTH-1:0]   mem_rd_addr_o,
    input  logic                            mem_rsp_valid_i,
    input  dcache_pkg::dcache_line_t        mem_rsp_line_i,
    output logic                            mem_wr_o,
    output logic [`DCACHE_ADDR_WIDTH-1:0]   mem_wr_addr_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]   mem_wr_data_o,
    output logic [`DCACHE_WORD_WIDTH/8-1:0] mem_wr_be_o,
    dcache_data_if.ctrl                     bus
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {IDLE, REFILL, RESPOND} state_e;

    state_e                        state_q;
    state_e                        state_d;
    logic [`DCACHE_ADDR_WIDTH-1:0] pend_addr_q;
    memop_size_e                   pend_size_q;
    logic [`DCACHE_ADDR_WIDTH-1:0] cur_addr;
    memop_size_e                   cur_size;
    logic                          load_hit;
    logic                          load_miss;
    logic                          store;
    logic                          refill_done;
    logic [`DCACHE_WORD_WIDTH/8-1:0] size_be;

    assign load_hit    = (state_q == IDLE) && req_i && !we_i && hit_i;
    assign load_miss   = (state_q == IDLE) && req_i && !we_i && !hit_i;
    assign store       = (state_q == IDLE) && req_i && we_i;
    assign refill_done = (state_q == REFILL) && mem_rsp_valid_i;

    // New request when idle, otherwise the pending refill.
    assign cur_addr = (state_q == IDLE) ? addr_i : pend_addr_q;
    assign cur_size = (state_q == IDLE) ? size_i : pend_size_q;

    assign lookup_tag_o   = cur_addr[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_BITS];
    assign lookup_index_o = cur_addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign tag_fill_o     = refill_done;

    assign bus.rd        = load_hit || (state_q == RESPOND);
    assign bus.wr        = store && hit_i;
    assign bus.fill      = refill_done;
    assign bus.index     = lookup_index_o;
    assign bus.offset    = cur_addr[`DCACHE_OFFSET_BITS-1:0];
    assign bus.size      = cur_size;
    assign bus.wdata     = wdata_i;
    assign bus.fill_line = mem_rsp_line_i;

    assign busy_o        = (state_q != IDLE);
    assign mem_rd_addr_o = {pend_addr_q[`DCACHE_ADDR_WIDTH-1:`DCACHE_OFFSET_BITS],
                            {`DCACHE_OFFSET_BITS{1'b0}}};

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (load_miss) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp_valid_i) begin
                    state_d = RESPOND;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        unique case (size_i)
            MEM_BYTE: size_be = 4'b0001;
            MEM_HALF: size_be = 4'b0011;
            default:  size_be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            rsp_valid_o  <= 1'b0;
            mem_rd_req_o <= 1'b0;
            mem_wr_o     <= 1'b0;
        end else begin
            state_q      <= state_d;
            rsp_valid_o  <= load_hit || (state_q == RESPOND);
            mem_rd_req_o <= load_miss;
            mem_wr_o     <= store;
        end
    end

    // Write-through goes out whether or not the store hit.
    always_ff @(posedge clk_i) begin
        if (load_miss) begin
            pend_addr_q <= addr_i;
            pend_size_q <= size_i;
        end
        if (store) begin
            mem_wr_addr_o <= {addr_i[`DCACHE_ADDR_WIDTH-1:2], 2'b00};
            mem_wr_data_o <= wdata_i << {addr_i[1:0], 3'b000};
            mem_wr_be_o   <= size_be << addr_i[1:0];
        end
    end

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_o |-> !req_i)
        else $error("dcache_ctrl: request while busy");

    a_rsp_in_refill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_valid_i |-> (state_q == REFILL))
        else $error("dcache_ctrl: memory response without a pending refill");

endmodule : dcache_ctrl

`default_nettype wire

// File: hw/dcache_data.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_data (
    input logic         clk_i,
    input logic         rst_n_i,
    dcache_data_if.data bus
);
    import dcache_pkg::*;

    localparam int word_bytes = `DCACHE_WORD_WIDTH / 8;

    dcache_line_t [`DCACHE_NUM_LINES-1:0] lines;

    logic [word_bytes-1:0]         size_be;
    logic [`DCACHE_WORD_WIDTH-1:0] gathered;
    logic [`DCACHE_WORD_WIDTH-1:0] rd_word;

    // Lanes touched by an access, counted up from the offset.
    always_comb begin
        unique case (bus.size)
            MEM_BYTE: size_be = 4'b0001;
            MEM_HALF: size_be = 4'b0011;
            default:  size_be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lines <= '0;
        end else if (bus.fill) begin
            lines[bus.index] <= bus.fill_line;
        end else if (bus.wr) begin
            for (int b = 0; b < word_bytes; b++) begin
                if (size_be[b]) begin
                    lines[bus.index][bus.offset + dcache_offset_t'(b)] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Bytes above the access size may wrap past the line end; they are masked below.
    always_comb begin
        for (int b = 0; b < word_bytes; b++) begin
            gathered[8*b +: 8] = lines[bus.index][bus.offset + dcache_offset_t'(b)];
        end
        rd_word = '0;
        unique case (bus.size)
            MEM_BYTE: rd_word[7:0] = gathered[7:0];
            MEM_HALF: rd_word[15:0] = gathered[15:0];
            default:  rd_word = gathered;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus.rd) begin
            bus.rdata <= rd_word;
        end
    end

    a_wr_fill_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(bus.wr && bus.fill))
        else $error("dcache_data: wr and fill in the same cycle");

    // Misaligned accesses from the core are not supported.
    a_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus.rd || bus.wr) |->
            ((bus.size == MEM_HALF) -> !bus.offset[0]) &&
            ((bus.size == MEM_WORD) -> (bus.offset[1:0] == 2'b00)))
        else $error("dcache_data: misaligned access at offset %0d", bus.offset);

endmodule : dcache_data

`default_nettype wire

// File: hw/dcache_data_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

interface dcache_data_if;
    import dcache_pkg::*;

    logic                          rd;
    logic                          wr;
    logic                          fill;
    dcache_index_t                 index;
    dcache_offset_t                offset;
    memop_size_e                   size;
    logic [`DCACHE_WORD_WIDTH-1:0] wdata;
    dcache_line_t                  fill_line;
    // Registered, valid the cycle after rd.
    logic [`DCACHE_WORD_WIDTH-1:0] rdata;

    modport ctrl (
        output rd, wr, fill, index, offset, size, wdata, fill_line,
        input  rdata
    );

    modport data (
        input  rd, wr, fill, index, offset, size, wdata, fill_line,
        output rdata
    );

endinterface : dcache_data_if

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // Access size of a load or store.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } memop_size_e;

    // Byte position inside a line.
    typedef logic [`DCACHE_OFFSET_BITS-1:0] dcache_offset_t;

    // Line select.
    typedef logic [`DCACHE_INDEX_BITS-1:0] dcache_index_t;

    typedef logic [`DCACHE_TAG_BITS-1:0] dcache_tag_t;

    // One line, byte 0 in the low bits.
    typedef logic [`DCACHE_LINE_BYTES-1:0][7:0] dcache_line_t;

endpackage : dcache_pkg

`default_nettype wire

// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Core-side widths.
`define DCACHE_ADDR_WIDTH 32
`define DCACHE_WORD_WIDTH 32

// Cache geometry.
`define DCACHE_LINE_BYTES 16
`define DCACHE_NUM_LINES 8

// Address split into tag, index and offset fields.
`define DCACHE_OFFSET_BITS 4
`define DCACHE_INDEX_BITS 3
`define DCACHE_TAG_BITS (`DCACHE_ADDR_WIDTH - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

`endif

// File: hw/dcache_tag.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  dcache_pkg::dcache_index_t lookup_index_i,
    input  dcache_pkg::dcache_tag_t   lookup_tag_i,
    input  logic                      fill_i,
    input  dcache_pkg::dcache_index_t fill_index_i,
    input  dcache_pkg::dcache_tag_t   fill_tag_i,
    output logic                      hit_o
);
    import dcache_pkg::*;

    logic [`DCACHE_NUM_LINES-1:0] valid_q;
    dcache_tag_t                  tags_q [`DCACHE_NUM_LINES];

    // Reset invalidates every line.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[fill_index_i] <= fill_tag_i;
        end
    end

    // Combinational lookup.
    always_comb begin
        hit_o = valid_q[lookup_index_i] && (tags_q[lookup_index_i] == lookup_tag_i);
    end

endmodule : dcache_tag

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Core side.
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [`DCACHE_ADDR_WIDTH-1:0]   addr_i,
    input  dcache_pkg::memop_size_e         size_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]   wdata_i,
    output logic                            rsp_valid_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]   rdata_o,
    output logic                            busy_o,
    // Memory side.
    output logic                            mem_rd_req_o,
    output logic [`DCACHE_ADDR_WIDTH-1:0]   mem_rd_addr_o,
    input  logic                            mem_rsp_valid_i,
    input  dcache_pkg::dcache_line_t        mem_rsp_line_i,
    output logic                            mem_wr_o,
    output logic [`DCACHE_ADDR_WIDTH-1:0]   mem_wr_addr_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]   mem_wr_data_o,
    output logic [`DCACHE_WORD_WIDTH/8-1:0] mem_wr_be_o
);
    import dcache_pkg::*;

    logic          hit;
    logic          tag_fill;
    dcache_index_t lookup_index;
    dcache_tag_t   lookup_tag;

    dcache_data_if data_bus ();

    dcache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_i           (req_i),
        .we_i            (we_i),
        .addr_i          (addr_i),
        .size_i          (size_i),
        .wdata_i         (wdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .busy_o          (busy_o),
        .hit_i           (hit),
        .tag_fill_o      (tag_fill),
        .lookup_index_o  (lookup_index),
        .lookup_tag_o    (lookup_tag),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_line_i  (mem_rsp_line_i),
        .mem_wr_o        (mem_wr_o),
        .mem_wr_addr_o   (mem_wr_addr_o),
        .mem_wr_data_o   (mem_wr_data_o),
        .mem_wr_be_o     (mem_wr_be_o),
        .bus             (data_bus.ctrl)
    );

    // During a refill the lookup address is the pending one, so it doubles as the fill address.
    dcache_tag u_tag (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .fill_i         (tag_fill),
        .fill_index_i   (lookup_index),
        .fill_tag_i     (lookup_tag),
        .hit_o          (hit)
    );

    dcache_data u_data (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (data_bus.data)
    );

    assign rdata_o = data_bus.rdata;

endmodule : dcache_top

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f build.f || exit 1
out="$(./obj_dir/Vtb_dcache 2>&1)"
echo "$out"
echo "$out" | grep -q "^Done: no errors$" && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
